// ==== Bender.yml ====
package:
  name: nes_bus

export_include_dirs:
  - include

sources:
  - files:
      - source/nes_bus_pkg.sv
      - source/cpu_clock_gen.sv
      - source/dmc_dma.sv
      - source/oam_dma.sv
      - source/bus_arbiter.sv
      - source/nes_bus_top.sv
  - target: test
    files:
      - dv/nes_bus_assertions.sv
      - dv/tb_nes_bus.sv

// ==== dv/nes_bus_assertions.sv ====
// Concurrent checks on the bus arbiter, attached to every bus_arbiter by bind
// Covers the sprite trigger source, DMC grant placement and the CPU stall
module nes_bus_assertions (
	input logic clk,
	input logic reset,
	input logic dmc_ack,
	input logic oam_active,
	input logic oam_write,
	input logic oam_start,
	input logic cpu_rnw,
	input logic cpu_pause
);

	int fail_count = 0; // Failed properties so far

	// Any cycle taken from the CPU has it stalled
	grant_pauses_cpu: assert property (@(posedge clk) disable iff (reset)
		(dmc_ack || oam_active) |-> cpu_pause)
		else begin
			fail_count++;
			$error("bus granted to DMA while the CPU runs");
		end

	// DMC grants fall on even cycles and sprite writes on odd ones
	dmc_no_write: assert property (@(posedge clk) disable iff (reset) dmc_ack |-> !oam_write)
		else begin
			fail_count++;
			$error("DMC grant on a sprite write cycle");
		end

	// Sprite trigger is a CPU-owned write
	start_by_cpu: assert property (@(posedge clk) disable iff (reset)
		oam_start |-> (!cpu_rnw && !dmc_ack && !oam_active))
		else begin
			fail_count++;
			$error("sprite DMA start without a CPU write");
		end

endmodule

bind bus_arbiter nes_bus_assertions i_assert (.clk(clk), .reset(reset), .dmc_ack(dmc_ack),
	.oam_active(oam_active), .oam_write(oam_write), .oam_start(oam_start),
	.cpu_rnw(cpu_rnw), .cpu_pause(cpu_pause));

// ==== dv/tb_nes_bus.sv ====
// Testbench for the console CPU bus, random traffic checked by a cycle model
// Inputs change right after the cpu_ce edge, outputs are checked at its negedge
`include "nes_bus_defines.svh"

module tb_nes_bus;

	localparam int max_cycles = 2200; // Upper bound over all tests
	logic clk = 0, reset = 1, cpu_rnw = 1, dmc_req = 0, mic = 0;
	logic [15:0] cpu_addr = 0, dmc_addr = 0, bus_addr;
	logic [15:0] next_addr; // Random CPU address before it is driven
	logic [7:0] cpu_dout = 0, mem_din = 0, bus_dout, cpu_din;
	logic [3:0] joypad_data = 0;
	logic cpu_ce, cpu_pause, dmc_ack, bus_read, bus_write, joypad_strobe;
	logic [1:0] joypad_clock;
	logic [31:0] rng = 59;
	int errors = 0, checks = 0, gap, acks, oam_writes, t_err, n;
	logic m_odd = 1, m_dmc = 0, m_ack = 0; // Model state
	int m_oam = 0; // 0 idle, 1 hold, 2 active
	logic [7:0] m_page, m_off, m_latch, m_last = 0;

	nes_bus_top i_dut (.*);

	always #2 clk = ~clk;

	initial begin
		#(max_cycles * `NES_CPU_DIV * 4 + 400);
		$display("Watchdog expired, the tests did not finish");
		$display("Errors found");
		$finish;
	end

	function automatic logic [15:0] rand16();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng[30:15];
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, msg, got, exp);
		end
	endtask

	// Read data by the register rules, open bus is the previous read byte
	function automatic logic [7:0] expect_din(input logic [15:0] a);
		if (a == `NES_JOY1_REG) return {m_last[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
		if (a == `NES_JOY2_REG) return {m_last[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
		if (a >= `NES_APU_BASE && a < `NES_APU_END) return m_last;
		return mem_din;
	endfunction

	// Wait for the end of a CPU cycle, check it against the model, advance
	task automatic run_cycle();
		logic act, wr, rd, we;
		logic [15:0] a;
		logic [7:0] d, din;
		gap = 0;
		do begin
			@(negedge clk);
			gap++;
		end while (!cpu_ce);
		m_ack = m_dmc && !m_odd;
		act = (m_oam == 2);
		wr = act && m_odd;
		a = cpu_addr;
		d = cpu_dout;
		rd = cpu_rnw;
		we = !cpu_rnw;
		if (m_ack) begin
			a = dmc_addr;
			rd = 1;
			we = 0;
		end else if (act) begin
			a = m_odd ? `NES_OAM_DATA_REG : {m_page, m_off};
			d = m_latch;
			rd = !wr;
			we = wr;
		end
		din = expect_din(a);
		check(bus_addr, a, "bus_addr");
		check({bus_read, bus_write}, {rd, we}, "read/write strobes");
		if (we) check(bus_dout, d, "bus_dout");
		check(cpu_din, din, "cpu_din");
		check(dmc_ack, m_ack, "dmc_ack");
		check(cpu_pause, (m_oam != 0) || dmc_req, "cpu_pause");
		check(joypad_strobe, a == `NES_JOY1_REG && we && d[0], "joypad_strobe");
		check(joypad_clock, {a == `NES_JOY2_REG && rd, a == `NES_JOY1_REG && rd}, "joypad_clock");
		acks += dmc_ack; // Grants and sprite writes as the DUT shows them
		oam_writes += bus_write && bus_addr == `NES_OAM_DATA_REG;
		m_last = din;
		if (act) m_latch = din;
		if (!m_dmc) m_dmc = dmc_req && cpu_rnw && !m_odd;
		else if (!m_odd) m_dmc = 0; // Grant cycle done
		if (we && a == `NES_OAM_DMA_REG) begin
			m_oam = 1;
			m_page = d;
			m_off = 0;
		end else if (m_oam == 1 && cpu_rnw && m_odd) m_oam = 2;
		else if (act && !m_odd && m_ack) m_oam = 1; // Stolen read, retried later
		else if (act && m_odd) begin
			if (m_off == 8'hff) m_oam = 0;
			m_off++;
		end
		m_odd = !m_odd;
		@(posedge clk);
		mem_din <= rand16();
		if (m_ack) dmc_req <= 0; // Sample logic drops its request after the grant
	endtask

	task automatic cpu_idle();
		cpu_rnw <= 1;
		cpu_addr <= rand16() & 16'h3fff;
	endtask

	task automatic sprite_dma(input int steal_at);
		cpu_rnw <= 0;
		cpu_addr <= `NES_OAM_DMA_REG;
		cpu_dout <= (rand16() & 8'h3f) | 8'h80; // Source page outside the I/O window
		run_cycle();
		cpu_idle();
		oam_writes = 0;
		acks = 0;
		n = 0;
		while (m_oam != 0) begin
			n++;
			if (n == steal_at) begin
				dmc_req <= 1;
				dmc_addr <= rand16();
			end
			run_cycle();
		end
		check(oam_writes, 256, "sprite DMA write count");
		if (steal_at > 0) check(acks, 1, "DMC grants during sprite DMA");
	endtask

	task automatic report(input string name);
		$display("test %s: %0d errors", name, errors - t_err);
		t_err = errors;
	endtask

	initial begin
		repeat (4) @(posedge clk);
		reset <= 0;
		t_err = 0;
		run_cycle();
		check(gap, `NES_CPU_DIV, "clocks to first cpu_ce");
		repeat (5) begin
			run_cycle();
			check(gap, `NES_CPU_DIV, "cpu_ce spacing");
		end
		report("clock divider");
		repeat (200) begin
			next_addr = rand16();
			if (next_addr >= `NES_APU_BASE && next_addr < `NES_APU_END)
				next_addr = 16'h8000; // Keep clear of the I/O window
			cpu_addr <= next_addr;
			cpu_rnw <= rand16() & 1;
			cpu_dout <= rand16();
			run_cycle();
		end
		report("CPU bus passthrough");
		repeat (200) begin
			n = rand16();
			case (n % 4)
				0: cpu_addr <= `NES_JOY1_REG;
				1: cpu_addr <= `NES_JOY2_REG;
				2: cpu_addr <= `NES_APU_BASE + (rand16() % 16'h14);
				default: cpu_addr <= rand16() & 16'h3fff;
			endcase
			cpu_rnw <= rand16() & 1;
			cpu_dout <= rand16();
			joypad_data <= rand16();
			mic <= rand16() & 1;
			run_cycle();
		end
		report("register decode");
		sprite_dma(0);
		report("sprite DMA");
		cpu_idle();
		while (m_odd) run_cycle();
		acks = 0;
		dmc_req <= 1;
		dmc_addr <= rand16();
		repeat (6) run_cycle();
		check(acks, 1, "DMC grants for one request");
		sprite_dma(20 + rand16() % 400);
		report("DMC DMA");
		check(i_dut.u_arbiter.i_assert.fail_count, 0, "bus assertion failures");
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) $display("No errors");
		else $display("Errors found");
		$finish;
	end

endmodule

// ==== include/nes_bus_defines.svh ====
// Register map and timing constants for the CPU-side console bus
// Include wherever a block decodes bus addresses or counts master clocks
`ifndef NES_BUS_DEFINES_SVH
`define NES_BUS_DEFINES_SVH

// Master clocks per CPU cycle
`define NES_CPU_DIV 12

// Sprite DMA trigger, write the source page here
`define NES_OAM_DMA_REG 16'h4014
// Sprite data port that DMA writes land on
`define NES_OAM_DATA_REG 16'h2004

`define NES_JOY1_REG 16'h4016 // Joypad 1, strobe on write
`define NES_JOY2_REG 16'h4017 // Joypad 2

// I/O register window, upper bound is exclusive
`define NES_APU_BASE 16'h4000
`define NES_APU_END 16'h4018

`endif

// ==== source/bus_arbiter.sv ====
// Shared CPU bus arbiter and register decoder
// Picks the bus owner, stalls the CPU during DMA, decodes the sprite DMA
// and joypad registers, and builds the read data with open-bus bits
`include "nes_bus_defines.svh"

module bus_arbiter (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dmc_ack,
	input  logic                   dmc_req,
	input  logic                   oam_hold,
	input  logic                   oam_active,
	input  logic                   oam_write,
	input  logic                   cpu_rnw,
	input  logic                   mic,
	input  nes_bus_pkg::bus_addr_u cpu_addr,
	input  nes_bus_pkg::bus_addr_u dmc_addr,
	input  nes_bus_pkg::bus_addr_u oam_addr,
	input  nes_bus_pkg::byte_t     cpu_dout,
	input  nes_bus_pkg::byte_t     oam_wdata,
	input  nes_bus_pkg::byte_t     mem_din,
	input  logic [3:0]             joypad_data,
	output nes_bus_pkg::bus_addr_u bus_addr,
	output nes_bus_pkg::byte_t     bus_dout,
	output nes_bus_pkg::byte_t     bus_rdata,
	output logic                   bus_read,
	output logic                   bus_write,
	output logic                   cpu_pause,
	output logic                   oam_start,
	output logic                   joypad_strobe,
	output logic [1:0]             joypad_clock
);

	nes_bus_pkg::byte_t open_bus; // Last value seen on the data bus
	logic joy1_sel;
	logic joy2_sel;
	logic io_sel;

	// Owner select, DMC beats sprite DMA beats the CPU
	always_comb begin
		bus_addr  = cpu_addr;
		bus_dout  = cpu_dout;
		bus_read  = cpu_rnw;
		bus_write = !cpu_rnw;
		if (dmc_ack) begin
			bus_addr  = dmc_addr; // DMC only ever reads
			bus_read  = 1'b1;
			bus_write = 1'b0;
		end else if (oam_active) begin
			bus_addr  = oam_addr;
			bus_dout  = oam_wdata;
			bus_read  = !oam_write;
			bus_write = oam_write;
		end
	end

	// CPU sits still while sprite DMA holds it or a DMC fetch is pending
	assign cpu_pause = oam_hold || dmc_req;

	// Decode on the address actually driven on the bus
	assign joy1_sel = (bus_addr.full == `NES_JOY1_REG);
	assign joy2_sel = (bus_addr.full == `NES_JOY2_REG);
	assign io_sel   = (bus_addr.full >= `NES_APU_BASE) && (bus_addr.full < `NES_APU_END);

	assign oam_start     = bus_write && (bus_addr.full == `NES_OAM_DMA_REG);
	assign joypad_strobe = joy1_sel && bus_write && bus_dout[0];
	assign joypad_clock  = {joy2_sel && bus_read, joy1_sel && bus_read};

	// Read data, undriven joypad bits float to open bus
	always_comb begin
		if (reset)
			bus_rdata = 8'h00;
		else if (joy1_sel)
			bus_rdata = {open_bus[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
		else if (joy2_sel)
			bus_rdata = {open_bus[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
		else if (io_sel)
			bus_rdata = open_bus; // Nothing else answers in the I/O window
		else
			bus_rdata = mem_din;
	end

	// Bus capacitance keeps the previous byte
	always_ff @(posedge clk) begin
		open_bus <= bus_rdata;
	end

endmodule

// ==== source/cpu_clock_gen.sv ====
// CPU clock enable and cycle phase from the master clock
// Every other block steps its state only when cpu_ce is high
`include "nes_bus_defines.svh"

module cpu_clock_gen (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,
	output logic odd_cycle
);

	localparam int div_w = $clog2(`NES_CPU_DIV);

	logic [div_w-1:0] div_cnt; // Master clocks into the current CPU cycle

	// Last master clock of the CPU cycle
	assign cpu_ce = (div_cnt == div_w'(`NES_CPU_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (cpu_ce) begin
			div_cnt <= '0; // Wrap, next cycle starts
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// DMA reads land on even cycles and writes on odd ones
	always_ff @(posedge clk) begin
		if (reset)
			odd_cycle <= 1'b1; // First cycle out of reset counts as odd
		else if (cpu_ce)
			odd_cycle <= ~odd_cycle;
	end

endmodule

// ==== source/dmc_dma.sv ====
// DMC sample DMA, steals one even CPU cycle per request
// dmc_ack is the grant and also tells the sample logic its byte is on the bus
module dmc_dma (
	input  logic clk,
	input  logic reset,
	input  logic cpu_ce,
	input  logic odd_cycle,
	input  logic dmc_req,
	input  logic cpu_rnw,
	output logic dmc_ack
);

	logic dmc_active; // Request accepted, waiting for or in the grant cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_active <= 1'b0;
		end else if (cpu_ce) begin
			if (!dmc_active) begin
				// Only start where the CPU is reading, on an even phase
				if (dmc_req && cpu_rnw && !odd_cycle)
					dmc_active <= 1'b1;
			end else if (!odd_cycle) begin
				dmc_active <= 1'b0; // Grant cycle just ended
			end
		end
	end

	// The odd cycle after the start is idle, the even one after it is granted
	assign dmc_ack = dmc_active && !odd_cycle;

endmodule

// ==== source/nes_bus_pkg.sv ====
// Shared types for the CPU-side bus
// Modules refer to these by scoped name
package nes_bus_pkg;

	// One byte on the data bus
	typedef logic [7:0] byte_t;

	// Bus address, seen whole by the decoder and as page:offset by sprite DMA
	typedef union packed {
		logic [15:0] full;
		struct packed {
			byte_t page;   // High byte
			byte_t offset; // Low byte, walks 00..FF during DMA
		} part;
	} bus_addr_u;

endpackage

// ==== source/nes_bus_top.sv ====
// CPU-side bus of the console
// CPU core, memory and DMC sample logic sit outside and connect here
module nes_bus_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_rnw,     // CPU read, low for write
	input  logic               dmc_req,     // Level from the DMC sample logic
	input  logic               mic,
	input  logic [15:0]        cpu_addr,
	input  logic [15:0]        dmc_addr,
	input  nes_bus_pkg::byte_t cpu_dout,
	input  nes_bus_pkg::byte_t mem_din,
	input  logic [3:0]         joypad_data,
	output logic               cpu_ce,      // Step enable for the CPU core
	output logic               cpu_pause,   // CPU ready, inverted
	output logic               dmc_ack,     // One cycle grant for the DMC fetch
	output logic               bus_read,
	output logic               bus_write,
	output logic               joypad_strobe,
	output logic [15:0]        bus_addr,
	output nes_bus_pkg::byte_t bus_dout,
	output nes_bus_pkg::byte_t cpu_din,     // Read data back to the CPU
	output logic [1:0]         joypad_clock
);

	logic                   odd_cycle;
	logic                   oam_start;
	logic                   oam_hold;
	logic                   oam_active;
	logic                   oam_write;
	nes_bus_pkg::bus_addr_u oam_addr;
	nes_bus_pkg::byte_t     oam_wdata;

	cpu_clock_gen u_clock (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	dmc_dma u_dmc (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle),
		.dmc_req   (dmc_req),
		.cpu_rnw   (cpu_rnw),
		.dmc_ack   (dmc_ack)
	);

	oam_dma u_oam (
		.clk        (clk),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.odd_cycle  (odd_cycle),
		.oam_start  (oam_start),
		.cpu_rnw    (cpu_rnw),
		.dmc_ack    (dmc_ack),
		.cpu_dout   (cpu_dout),   // Page number from the trigger write
		.bus_rdata  (cpu_din),    // Source bytes come back on the read path
		.oam_hold   (oam_hold),
		.oam_active (oam_active),
		.oam_write  (oam_write),
		.oam_addr   (oam_addr),
		.oam_wdata  (oam_wdata)
	);

	bus_arbiter u_arbiter (
		.clk           (clk),
		.reset         (reset),
		.dmc_ack       (dmc_ack),
		.dmc_req       (dmc_req),
		.oam_hold      (oam_hold),
		.oam_active    (oam_active),
		.oam_write     (oam_write),
		.cpu_rnw       (cpu_rnw),
		.mic           (mic),
		.cpu_addr      (cpu_addr),
		.dmc_addr      (dmc_addr),
		.oam_addr      (oam_addr),
		.cpu_dout      (cpu_dout),
		.oam_wdata     (oam_wdata),
		.mem_din       (mem_din),
		.joypad_data   (joypad_data),
		.bus_addr      (bus_addr),
		.bus_dout      (bus_dout),
		.bus_rdata     (cpu_din),
		.bus_read      (bus_read),
		.bus_write     (bus_write),
		.cpu_pause     (cpu_pause),
		.oam_start     (oam_start),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock)
	);

endmodule

// ==== source/oam_dma.sv ====
// Sprite DMA engine, copies one 256-byte page into the sprite data port
// Started by oam_start, alternates even-cycle reads and odd-cycle writes
`include "nes_bus_defines.svh"

module oam_dma (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cpu_ce,
	input  logic                  odd_cycle,
	input  logic                  oam_start,
	input  logic                  cpu_rnw,
	input  logic                  dmc_ack,
	input  nes_bus_pkg::byte_t    cpu_dout,
	input  nes_bus_pkg::byte_t    bus_rdata,
	output logic                  oam_hold,
	output logic                  oam_active,
	output logic                  oam_write,
	output nes_bus_pkg::bus_addr_u oam_addr,
	output nes_bus_pkg::byte_t    oam_wdata
);

	// Bit 0 means the CPU is held, bit 1 means the engine owns the bus
	localparam logic [1:0] st_idle   = 2'b00;
	localparam logic [1:0] st_hold   = 2'b01;
	localparam logic [1:0] st_active = 2'b11;

	logic [1:0]             state;
	nes_bus_pkg::bus_addr_u src_addr;  // Source page:offset
	nes_bus_pkg::byte_t     byte_latch; // Last byte read

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else if (cpu_ce) begin
			if (oam_start) begin
				state <= st_hold; // Wait for a CPU read on an odd cycle
			end else begin
				case (state)
					st_hold:
						if (cpu_rnw && odd_cycle)
							state <= st_active;
					st_active:
						if (!odd_cycle && dmc_ack)
							state <= st_hold; // DMC stole this read, redo it
						else if (odd_cycle && src_addr.part.offset == 8'hff)
							state <= st_idle; // Last write done
					default: state <= st_idle;
				endcase
			end
		end
	end

	// Address and data latches
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (oam_start) begin
				src_addr.part.page   <= cpu_dout;
				src_addr.part.offset <= 8'h00;
			end else if (oam_active && odd_cycle) begin
				src_addr.part.offset <= src_addr.part.offset + 8'd1; // After each write
			end
			if (oam_active)
				byte_latch <= bus_rdata;
		end
	end

	assign oam_hold   = state[0];
	assign oam_active = (state == st_active);
	assign oam_write  = oam_active && odd_cycle;
	assign oam_wdata  = byte_latch;

	// Read from the source on even cycles, write the sprite port on odd ones
	assign oam_addr = odd_cycle ? nes_bus_pkg::bus_addr_u'(`NES_OAM_DATA_REG) : src_addr;

endmodule

// ==== verilog.f ====
+incdir+include
source/nes_bus_pkg.sv
source/cpu_clock_gen.sv
source/dmc_dma.sv
source/oam_dma.sv
source/bus_arbiter.sv
source/nes_bus_top.sv
dv/nes_bus_assertions.sv
dv/tb_nes_bus.sv
